//--- common/ccm_pkg.sv
`default_nettype none

package ccm_pkg;

   // pixel and coefficient formats
   localparam int DATA_WIDTH       = 10;
   localparam int COEFF_WIDTH      = 10;
   localparam int COEFF_FRAC_WIDTH = 8;
   localparam int N_CH             = 3;
   localparam int N_COEFF          = N_CH * N_CH;

   // datapath widths
   localparam int MULT_WIDTH  = DATA_WIDTH + COEFF_WIDTH;
   localparam int ACCUM_EXTRA = $clog2(N_CH);
   localparam int ACCUM_WIDTH = MULT_WIDTH + ACCUM_EXTRA;

   // first sum bit above the output field once the fraction is dropped
   localparam int TOP_POS = DATA_WIDTH + COEFF_FRAC_WIDTH;

   // configuration port
   localparam int CFG_ADDR_WIDTH = 4;
   localparam int CFG_DATA_WIDTH = 16;

   // coefficients at 0..8 (row * N_CH + col), mode at 9
   localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_MODE = 4'd9;

   // 1.0 in coefficient format
   localparam logic [COEFF_WIDTH-1:0] COEFF_ONE = 10'd256;

   // one config write word, read as a coefficient or as the mode
   typedef union packed {
      struct packed {
         logic [CFG_DATA_WIDTH-COEFF_WIDTH-1:0] pad;
         logic [COEFF_WIDTH-1:0]                value;
      } coeff;
      struct packed {
         logic [CFG_DATA_WIDTH-3:0] pad;
         logic                      signed_coeff;
         logic                      signed_data;
      } mode;
   } ccm_cfg_word_u;

endpackage

`default_nettype wire

//--- hdl/ccm_cfg_decode.sv
`timescale 1ns/10ps
`default_nettype none

module ccm_cfg_decode
   import ccm_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           cfg_we,
   input  logic [CFG_ADDR_WIDTH-1:0]      cfg_addr,
   input  logic [CFG_DATA_WIDTH-1:0]      cfg_wdata,
   output logic [N_COEFF*COEFF_WIDTH-1:0] coeff,
   output logic                           signed_coeff,
   output logic                           signed_data
);

   ccm_cfg_word_u wword;

   assign wword = cfg_wdata;

   // coefficient bank, identity after reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < N_COEFF; i++) begin
            // diagonal entries are every (N_CH+1)th address
            if (i % (N_CH + 1) == 0) begin
               coeff[i*COEFF_WIDTH +: COEFF_WIDTH] <= COEFF_ONE;
            end else begin
               coeff[i*COEFF_WIDTH +: COEFF_WIDTH] <= '0;
            end
         end
      end else if (cfg_we) begin
         for (int i = 0; i < N_COEFF; i++) begin
            if (cfg_addr == CFG_ADDR_WIDTH'(i)) begin
               coeff[i*COEFF_WIDTH +: COEFF_WIDTH] <= wword.coeff.value;
            end
         end
      end
   end

   // signedness mode, unsigned/unsigned after reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         signed_coeff <= 1'b0;
         signed_data  <= 1'b0;
      end else if (cfg_we && cfg_addr == ADDR_MODE) begin
         signed_coeff <= wword.mode.signed_coeff;
         signed_data  <= wword.mode.signed_data;
      end
   end

endmodule

`default_nettype wire

//--- dot_product/dot_product.sv
`timescale 1ns/10ps
`default_nettype none

module dot_product
   import ccm_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           dvi,
   input  logic [N_CH*DATA_WIDTH-1:0]     datai,
   input  logic [N_COEFF*COEFF_WIDTH-1:0] coeff,
   input  logic                           signed_coeff,
   input  logic                           signed_data,
   output logic                           accum_valid,
   output logic [N_CH*ACCUM_WIDTH-1:0]    accum,
   output logic                           accum_signed_coeff,
   output logic                           accum_signed_data
);

   logic [ACCUM_WIDTH-1:0] sum [N_CH];

   // one product, already extended to the accumulator width
   function automatic logic [ACCUM_WIDTH-1:0] term(
      input logic [COEFF_WIDTH-1:0] c,
      input logic [DATA_WIDTH-1:0]  d,
      input logic                   sc,
      input logic                   sd
   );
      logic [COEFF_WIDTH-1:0] c_mag;
      logic [DATA_WIDTH-1:0]  d_mag;
      logic [MULT_WIDTH-1:0]  mag;
      logic [MULT_WIDTH-1:0]  prod;
      // magnitudes, only used when the operand is treated as signed
      c_mag = c[COEFF_WIDTH-1] ? -c : c;
      d_mag = d[DATA_WIDTH-1] ? -d : d;
      case ({sc, sd})
         2'b11: begin
            prod = $signed(c) * $signed(d);
         end
         2'b10: begin
            // signed coeff times unsigned pixel via sign-magnitude
            mag  = c_mag * d;
            prod = c[COEFF_WIDTH-1] ? -mag : mag;
         end
         2'b01: begin
            mag  = c * d_mag;
            prod = d[DATA_WIDTH-1] ? -mag : mag;
         end
         default: begin
            prod = c * d;
         end
      endcase
      if (sc || sd) begin
         term = {{ACCUM_EXTRA{prod[MULT_WIDTH-1]}}, prod};
      end else begin
         // both unsigned, product cannot be negative
         term = {{ACCUM_EXTRA{1'b0}}, prod};
      end
      return term;
   endfunction

   // row r of the matrix against the pixel gives output channel r
   always_comb begin
      for (int r = 0; r < N_CH; r++) begin
         sum[r] = '0;
         for (int c = 0; c < N_CH; c++) begin
            sum[r] = sum[r] + term(coeff[(r*N_CH+c)*COEFF_WIDTH +: COEFF_WIDTH],
                                   datai[c*DATA_WIDTH +: DATA_WIDTH],
                                   signed_coeff,
                                   signed_data);
         end
      end
   end

   // strobe every cycle, mode follows the pixel it was applied to
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         accum_valid        <= 1'b0;
         accum_signed_coeff <= 1'b0;
         accum_signed_data  <= 1'b0;
      end else begin
         accum_valid <= dvi;
         if (dvi) begin
            accum_signed_coeff <= signed_coeff;
            accum_signed_data  <= signed_data;
         end
      end
   end

   // sums hold between pixels
   always_ff @(posedge clk) begin
      if (dvi) begin
         for (int r = 0; r < N_CH; r++) begin
            accum[r*ACCUM_WIDTH +: ACCUM_WIDTH] <= sum[r];
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/ccm_clamp.sv
`timescale 1ns/10ps
`default_nettype none

module ccm_clamp
   import ccm_pkg::*;
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        accum_valid,
   input  logic [N_CH*ACCUM_WIDTH-1:0] accum,
   input  logic                        accum_signed_coeff,
   input  logic                        accum_signed_data,
   output logic                        dvo,
   output logic [N_CH*DATA_WIDTH-1:0]  datao
);

   logic [DATA_WIDTH-1:0] clamped [N_CH];

   // saturate one sum and drop the fraction bits (floor)
   function automatic logic [DATA_WIDTH-1:0] clamp(
      input logic [ACCUM_WIDTH-1:0] s,
      input logic                   sc,
      input logic                   sd
   );
      logic [ACCUM_WIDTH-TOP_POS:0] upper;
      logic [DATA_WIDTH-1:0]        scaled;
      logic                         neg;
      upper  = s[ACCUM_WIDTH-1:TOP_POS-1];
      scaled = s[TOP_POS-1:COEFF_FRAC_WIDTH];
      neg    = s[ACCUM_WIDTH-1];
      if (sd) begin
         // two's complement output, upper bits must all match the sign
         if (&upper || ~|upper) begin
            clamp = scaled;
         end else if (neg) begin
            clamp = {1'b1, {(DATA_WIDTH-1){1'b0}}};
         end else begin
            clamp = {1'b0, {(DATA_WIDTH-1){1'b1}}};
         end
      end else if (sc && neg) begin
         // negative colour is black
         clamp = '0;
      end else if (|upper[ACCUM_WIDTH-TOP_POS:1]) begin
         clamp = '1;
      end else begin
         clamp = scaled;
      end
      return clamp;
   endfunction

   always_comb begin
      for (int ch = 0; ch < N_CH; ch++) begin
         clamped[ch] = clamp(accum[ch*ACCUM_WIDTH +: ACCUM_WIDTH],
                             accum_signed_coeff,
                             accum_signed_data);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dvo <= 1'b0;
      end else begin
         dvo <= accum_valid;
      end
   end

   // pixel word only changes with a valid sum
   always_ff @(posedge clk) begin
      if (accum_valid) begin
         for (int ch = 0; ch < N_CH; ch++) begin
            datao[ch*DATA_WIDTH +: DATA_WIDTH] <= clamped[ch];
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/ccm_top.sv
`timescale 1ns/10ps
`default_nettype none

module ccm_top
   import ccm_pkg::*;
(
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       cfg_we,
   input  logic [CFG_ADDR_WIDTH-1:0]  cfg_addr,
   input  logic [CFG_DATA_WIDTH-1:0]  cfg_wdata,
   input  logic                       dvi,
   input  logic [N_CH*DATA_WIDTH-1:0] datai,
   output logic                       dvo,
   output logic [N_CH*DATA_WIDTH-1:0] datao
);

   logic [N_COEFF*COEFF_WIDTH-1:0] coeff;
   logic                           signed_coeff;
   logic                           signed_data;
   logic                           accum_valid;
   logic [N_CH*ACCUM_WIDTH-1:0]    accum;
   logic                           accum_signed_coeff;
   logic                           accum_signed_data;

   // coefficient and mode registers
   ccm_cfg_decode cfg_decode_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .cfg_we       (cfg_we),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .coeff        (coeff),
      .signed_coeff (signed_coeff),
      .signed_data  (signed_data)
   );

   // stage 1, products and sums
   dot_product dot_product_i (
      .clk                (clk),
      .arst_n             (arst_n),
      .dvi                (dvi),
      .datai              (datai),
      .coeff              (coeff),
      .signed_coeff       (signed_coeff),
      .signed_data        (signed_data),
      .accum_valid        (accum_valid),
      .accum              (accum),
      .accum_signed_coeff (accum_signed_coeff),
      .accum_signed_data  (accum_signed_data)
   );

   // stage 2, saturate and scale
   ccm_clamp clamp_i (
      .clk                (clk),
      .arst_n             (arst_n),
      .accum_valid        (accum_valid),
      .accum              (accum),
      .accum_signed_coeff (accum_signed_coeff),
      .accum_signed_data  (accum_signed_data),
      .dvo                (dvo),
      .datao              (datao)
   );

endmodule

`default_nettype wire

//--- verif/ccm_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ccm_tb
   import ccm_pkg::*;
();

   localparam int DRAIN_LIMIT = 50;

   logic                       clk = 1'b0;
   logic                       arst_n;
   logic                       cfg_we;
   logic [CFG_ADDR_WIDTH-1:0]  cfg_addr;
   logic [CFG_DATA_WIDTH-1:0]  cfg_wdata;
   logic                       dvi;
   logic [N_CH*DATA_WIDTH-1:0] datai;
   logic                       dvo;
   logic [N_CH*DATA_WIDTH-1:0] datao;

   // testbench copy of what was last written
   logic [COEFF_WIDTH-1:0]     tb_coeff [N_COEFF];
   logic                       tb_sc;
   logic                       tb_sd;

   logic [N_CH*DATA_WIDTH-1:0] exp_q [$];
   logic [N_CH*DATA_WIDTH-1:0] exp_front;
   logic                       exp_valid;
   logic [31:0]                lfsr;
   int                         value_errors;
   int                         other_errors;

   ccm_top dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .dvi       (dvi),
      .datai     (datai),
      .dvo       (dvo),
      .datao     (datao)
   );

   always #5 clk = ~clk;

   // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   // exact integer dot product with floor scaling and the clamp rule of the mode
   function automatic logic [N_CH*DATA_WIDTH-1:0] model_pixel(
      input logic [N_CH*DATA_WIDTH-1:0] pix
   );
      logic [N_CH*DATA_WIDTH-1:0] res;
      logic [DATA_WIDTH-1:0]      d;
      int                         cv;
      int                         dv;
      int                         acc;
      int                         outv;
      for (int r = 0; r < N_CH; r++) begin
         acc = 0;
         for (int c = 0; c < N_CH; c++) begin
            d   = pix[c*DATA_WIDTH +: DATA_WIDTH];
            cv  = tb_sc ? int'($signed(tb_coeff[r*N_CH+c])) : int'(tb_coeff[r*N_CH+c]);
            dv  = tb_sd ? int'($signed(d)) : int'(d);
            acc = acc + cv * dv;
         end
         outv = acc >>> COEFF_FRAC_WIDTH;
         if (tb_sd) begin
            if (outv > 511) begin
               outv = 511;
            end
            if (outv < -512) begin
               outv = -512;
            end
         end else if (tb_sc && acc < 0) begin
            outv = 0;
         end else if (outv > 1023) begin
            outv = 1023;
         end
         res[r*DATA_WIDTH +: DATA_WIDTH] = outv[DATA_WIDTH-1:0];
      end
      return res;
   endfunction

   task automatic refresh_front();
      exp_valid = exp_q.size() > 0;
      if (exp_valid) begin
         exp_front = exp_q[0];
      end
   endtask

   // same address map as the DUT where 10..15 fall through
   task automatic apply_write(input logic [CFG_ADDR_WIDTH-1:0] addr,
                              input logic [CFG_DATA_WIDTH-1:0] wdata);
      if (addr < CFG_ADDR_WIDTH'(N_COEFF)) begin
         tb_coeff[addr] = wdata[COEFF_WIDTH-1:0];
      end else if (addr == ADDR_MODE) begin
         tb_sc = wdata[1];
         tb_sd = wdata[0];
      end
   endtask

   // one clock cycle of stimulus
   // a pixel sees the config from before this write
   task automatic drive_cycle(input logic                       we,
                              input logic [CFG_ADDR_WIDTH-1:0]  addr,
                              input logic [CFG_DATA_WIDTH-1:0]  wdata,
                              input logic                       v,
                              input logic [N_CH*DATA_WIDTH-1:0] pix);
      @(posedge clk);
      #1;
      cfg_we    = we;
      cfg_addr  = addr;
      cfg_wdata = wdata;
      dvi       = v;
      datai     = pix;
      if (v) begin
         exp_q.push_back(model_pixel(pix));
         refresh_front();
      end
      if (we) begin
         apply_write(addr, wdata);
      end
   endtask

   task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr,
                            input logic [CFG_DATA_WIDTH-1:0] wdata);
      drive_cycle(1'b1, addr, wdata, 1'b0, '0);
   endtask

   task automatic write_random_coeffs();
      logic [31:0] r;
      for (int i = 0; i < N_COEFF; i++) begin
         r = rand_bits(COEFF_WIDTH);
         write_cfg(CFG_ADDR_WIDTH'(i), {6'd0, r[COEFF_WIDTH-1:0]});
      end
   endtask

   task automatic stream_pixels(input int n, input logic gaps);
      logic [31:0] r;
      logic        v;
      for (int i = 0; i < n; i++) begin
         r = rand_bits(1);
         v = gaps ? r[0] : 1'b1;
         r = rand_bits(N_CH * DATA_WIDTH);
         drive_cycle(1'b0, '0, '0, v, r[N_CH*DATA_WIDTH-1:0]);
      end
   endtask

   // back-to-back pixels with random writes to any address and a mode write every 10th cycle
   task automatic stream_with_writes(input int n);
      logic [31:0]               r;
      logic                      we;
      logic [CFG_ADDR_WIDTH-1:0] addr;
      logic [CFG_DATA_WIDTH-1:0] wdata;
      for (int i = 0; i < n; i++) begin
         r     = rand_bits(1);
         we    = r[0] || (i % 10 == 0);
         r     = rand_bits(CFG_ADDR_WIDTH);
         addr  = (i % 10 == 0) ? ADDR_MODE : r[CFG_ADDR_WIDTH-1:0];
         r     = rand_bits(CFG_DATA_WIDTH);
         wdata = r[CFG_DATA_WIDTH-1:0];
         r     = rand_bits(N_CH * DATA_WIDTH);
         drive_cycle(we, addr, wdata, 1'b1, r[N_CH*DATA_WIDTH-1:0]);
      end
   endtask

   task automatic drain_outputs();
      int waited;
      drive_cycle(1'b0, '0, '0, 1'b0, '0);
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         other_errors++;
         $display("Timeout at %0t: %0d expected pixels never came out", $time, exp_q.size());
      end
   endtask

   task automatic finish_run();
      $display("error count: %0d mismatches, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   endtask

   // checks run mid-cycle where DUT outputs and queue front are settled
   assert property (@(negedge clk) disable iff (!arst_n) dvo == $past(dvi, 2))
      else begin
         value_errors++;
         $display("Mismatch at %0t: dvo is %b, not dvi of two cycles back", $time, dvo);
      end

   assert property (@(negedge clk) disable iff (!arst_n) dvo |-> exp_valid)
      else begin
         other_errors++;
         $display("Output pixel at %0t arrived with no expected pixel queued", $time);
      end

   assert property (@(negedge clk) disable iff (!arst_n)
                    (dvo && exp_valid) |-> datao == exp_front)
      else begin
         value_errors++;
         $display("Mismatch at %0t: datao ch0..2 = %0d %0d %0d, expected %0d %0d %0d",
                  $time, datao[9:0], datao[19:10], datao[29:20],
                  exp_front[9:0], exp_front[19:10], exp_front[29:20]);
      end

   // retire the checked pixel just after the check
   always @(negedge clk) begin
      #1;
      if (dvo && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
         refresh_front();
      end
   end

   initial begin
      arst_n       = 1'b0;
      cfg_we       = 1'b0;
      cfg_addr     = '0;
      cfg_wdata    = '0;
      dvi          = 1'b0;
      datai        = '0;
      lfsr         = 32'h146d;
      value_errors = 0;
      other_errors = 0;
      exp_valid    = 1'b0;
      exp_front    = '0;
      tb_sc        = 1'b0;
      tb_sd        = 1'b0;
      for (int i = 0; i < N_COEFF; i++) begin
         tb_coeff[i] = (i % (N_CH + 1) == 0) ? COEFF_ONE : '0;
      end
      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // identity after reset with gaps in the stream
      stream_pixels(40, 1'b1);

      // unsigned coefficients up to about 4.0 so full-scale pixels saturate
      write_random_coeffs();
      stream_pixels(50, 1'b0);
      drive_cycle(1'b0, '0, '0, 1'b1, {N_CH{10'h3ff}});

      // both signed with row 0 at -2.0 to drive both clamp limits
      write_cfg(ADDR_MODE, 16'h0003);
      write_random_coeffs();
      for (int i = 0; i < N_CH; i++) begin
         write_cfg(CFG_ADDR_WIDTH'(i), 16'h0200);
      end
      drive_cycle(1'b0, '0, '0, 1'b1, {N_CH{10'h200}});
      drive_cycle(1'b0, '0, '0, 1'b1, {N_CH{10'h1ff}});
      stream_pixels(50, 1'b0);

      // signed coefficients and unsigned data with row 0 negative and row 1 near 2.0
      write_cfg(ADDR_MODE, 16'h0002);
      write_random_coeffs();
      for (int i = 0; i < N_CH; i++) begin
         write_cfg(CFG_ADDR_WIDTH'(i), 16'h0300);
         write_cfg(CFG_ADDR_WIDTH'(N_CH + i), 16'h01ff);
      end
      stream_pixels(50, 1'b0);

      // unsigned coefficients and signed data
      write_cfg(ADDR_MODE, 16'h0001);
      write_random_coeffs();
      stream_pixels(50, 1'b0);

      // config changes under a running stream
      stream_with_writes(120);

      drain_outputs();
      finish_run();
   end

endmodule

`default_nettype wire

//--- all.f
common/ccm_pkg.sv
hdl/ccm_cfg_decode.sv
dot_product/dot_product.sv
hdl/ccm_clamp.sv
hdl/ccm_top.sv
verif/ccm_tb.sv

//--- run.sh
#!/bin/sh
# builds the colour correction matrix testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module ccm_tb -f all.f -o ccm_sim \
   || { echo "verilator build failed"; exit 1; }

./obj_dir/ccm_sim > sim.log 2>&1 \
   || echo "simulator exited with an error status" >> sim.log

cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
